//--- src/user_io_params.svh
`ifndef USER_IO_PARAMS_SVH
`define USER_IO_PARAMS_SVH

// core type reported in byte 0 of every reply
`define USER_IO_CORE_TYPE      8'ha6

// queue depths
`define USER_IO_KBD_DEPTH      4
`define USER_IO_SD_DEPTH       8

// upper nibbles of the status replies
`define USER_IO_KBD_STATUS_TAG 4'ha
`define USER_IO_SD_STATUS_TAG  4'h6

`endif

//--- src/user_io_pkg.sv
`default_nettype none

package user_io_pkg;

    // one byte as it travels over the SPI link
    typedef logic [7:0] spi_byte_t;

    // commands sent by the I/O controller in byte 0 of a frame
    typedef enum logic [7:0] {
        CMD_BUTTONS   = 8'h01,
        CMD_KBD_READ  = 8'h04,
        CMD_KBD_WRITE = 8'h05,
        CMD_SD_STATUS = 8'h16,
        CMD_SD_SECTOR = 8'h17,
        CMD_SD_CONF   = 8'h19,
        CMD_JOY0      = 8'h60,
        CMD_JOY1      = 8'h61
    } user_cmd_t;

    // position within a frame, sticks at 15 for long transfers
    typedef logic [3:0] byte_idx_t;

    // keyboard code handed to the core
    typedef logic [7:0] kbd_code_t;

    // sd queue entry, conf marks bytes that came from a config frame
    typedef struct packed {
        logic [7:0] data;
        logic       conf;
    } sd_item_t;

endpackage

`default_nettype wire

//--- src/byte_fifo.sv
`default_nettype none

module byte_fifo #(
    parameter type item_t = logic [7:0],
    parameter int  DEPTH  = 4
) (
    input  logic  SPI_CLK,
    input  logic  SPI_SS_IO,
    input  logic  push,
    input  item_t push_item,
    output logic  valid,
    output item_t item,
    input  logic  ready,
    output logic  overflow
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    item_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             pop;
    logic             accept;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full   = (count == CNT_W'(DEPTH));
    assign pop    = valid && ready;
    // a full queue still takes a push when the head leaves in the same cycle
    assign accept = push && (!full || pop);

    assign valid = (count != '0);
    assign item  = mem[rd_ptr];

    always_ff @(posedge SPI_CLK or posedge SPI_SS_IO) begin
        if (SPI_SS_IO) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (accept) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({accept, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // spi cannot wait, the byte is lost and the flag stays up
            if (push && !accept) begin
                overflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge SPI_CLK) begin
        if (accept) begin
            mem[wr_ptr] <= push_item;
        end
    end

    a_count_bound: assert property (
        @(posedge SPI_CLK) disable iff (SPI_SS_IO)
        count <= CNT_W'(DEPTH)
    );

endmodule

`default_nettype wire

//--- src/spi_byte_rx.sv
`default_nettype none

module spi_byte_rx (
    input  logic                  SPI_CLK,
    input  logic                  SPI_SS_IO,
    input  logic                  spi_sel,
    input  logic                  mosi,
    output logic                  byte_strobe,
    output user_io_pkg::spi_byte_t rx_byte,
    output user_io_pkg::byte_idx_t byte_idx,
    output logic [2:0]            bit_idx
);
    import user_io_pkg::*;

    // first seven bits of the byte in flight, msb first
    logic [6:0] sbuf;

    // bit_idx is the next bit to sample, byte_idx the byte it belongs to
    always_ff @(posedge SPI_CLK or posedge SPI_SS_IO) begin
        if (SPI_SS_IO) begin
            bit_idx     <= '0;
            byte_idx    <= '0;
            byte_strobe <= 1'b0;
        end else if (!spi_sel) begin
            // frame gap, start over at byte 0 bit 0
            bit_idx     <= '0;
            byte_idx    <= '0;
            byte_strobe <= 1'b0;
        end else begin
            bit_idx     <= bit_idx + 3'd1;
            byte_strobe <= (bit_idx == 3'd7);
            if (bit_idx == 3'd7 && byte_idx != 4'd15) begin
                byte_idx <= byte_idx + 4'd1;
            end
        end
    end

    always_ff @(posedge SPI_CLK) begin
        if (spi_sel) begin
            if (bit_idx == 3'd7) begin
                rx_byte <= {sbuf, mosi};
            end else begin
                sbuf <= {sbuf[5:0], mosi};
            end
        end
    end

    // one strobe per eight bits, so two in a row means the counter slipped
    a_strobe_single: assert property (
        @(posedge SPI_CLK) disable iff (SPI_SS_IO)
        byte_strobe |=> !byte_strobe
    );

endmodule

`default_nettype wire

//--- src/cmd_decoder.sv
`default_nettype none

module cmd_decoder (
    input  logic                   SPI_CLK,
    input  logic                   SPI_SS_IO,
    input  logic                   byte_strobe,
    input  user_io_pkg::spi_byte_t rx_byte,
    input  user_io_pkg::byte_idx_t byte_idx,
    output user_io_pkg::user_cmd_t cur_cmd,
    output logic [1:0]             buttons,
    output logic [1:0]             switches,
    output logic                   scandoubler_disable,
    output logic                   ypbpr,
    output logic [7:0]             joy0,
    output logic [7:0]             joy1,
    output logic                   kbd_push,
    output user_io_pkg::kbd_code_t kbd_push_item,
    output logic                   sd_push,
    output user_io_pkg::sd_item_t  sd_push_item,
    input  logic                   kbd_out_strobe,
    output logic                   kbd_avail
);
    import user_io_pkg::*;

    user_cmd_t cmd_q;
    logic      cmd_byte;
    logic      first_arg;

    // byte_idx has already moved past the byte being strobed
    assign cmd_byte  = byte_strobe && (byte_idx == 4'd1);
    assign first_arg = byte_strobe && (byte_idx == 4'd2);

    // forward the new command so the reply for byte 1 starts on time
    assign cur_cmd = cmd_byte ? user_cmd_t'(rx_byte) : cmd_q;

    always_ff @(posedge SPI_CLK or posedge SPI_SS_IO) begin
        if (SPI_SS_IO) begin
            cmd_q               <= user_cmd_t'(8'h00);
            buttons             <= '0;
            switches            <= '0;
            scandoubler_disable <= 1'b0;
            ypbpr               <= 1'b0;
            joy0                <= '0;
            joy1                <= '0;
            kbd_push            <= 1'b0;
            sd_push             <= 1'b0;
            kbd_avail           <= 1'b0;
        end else begin
            kbd_push <= 1'b0;
            sd_push  <= 1'b0;
            if (cmd_byte) begin
                cmd_q <= user_cmd_t'(rx_byte);
            end else if (byte_strobe) begin
                case (cmd_q)
                    CMD_BUTTONS: if (first_arg) begin
                        buttons             <= rx_byte[1:0];
                        switches            <= rx_byte[3:2];
                        scandoubler_disable <= rx_byte[4];
                        ypbpr               <= rx_byte[5];
                    end
                    CMD_JOY0:      if (first_arg) joy0 <= rx_byte;
                    CMD_JOY1:      if (first_arg) joy1 <= rx_byte;
                    CMD_KBD_WRITE: kbd_push <= first_arg;
                    CMD_KBD_READ:  if (first_arg) kbd_avail <= 1'b0;
                    // sector and config data stream for the whole frame
                    CMD_SD_SECTOR: sd_push <= 1'b1;
                    CMD_SD_CONF:   sd_push <= 1'b1;
                    default: ;
                endcase
            end
            // a new key from the core wins over the read clearing it
            if (kbd_out_strobe) begin
                kbd_avail <= 1'b1;
            end
        end
    end

    always_ff @(posedge SPI_CLK) begin
        if (byte_strobe) begin
            kbd_push_item     <= rx_byte;
            sd_push_item.data <= rx_byte;
            sd_push_item.conf <= (cmd_q == CMD_SD_CONF);
        end
    end

endmodule

`default_nettype wire

//--- src/spi_reply_tx.sv
`default_nettype none

`include "user_io_params.svh"

module spi_reply_tx (
    input  logic                   SPI_CLK,
    input  logic                   SPI_SS_IO,
    input  logic                   spi_sel,
    input  user_io_pkg::byte_idx_t byte_idx,
    input  logic [2:0]             bit_idx,
    input  user_io_pkg::user_cmd_t cur_cmd,
    input  logic                   kbd_avail,
    input  logic [7:0]             kbd_out_data,
    input  logic                   sd_conf,
    input  logic                   sd_sdhc,
    input  logic                   sd_rd,
    input  logic                   sd_wr,
    output logic                   miso
);
    import user_io_pkg::*;

    spi_byte_t reply_next;
    spi_byte_t tx_byte;
    logic      miso_q;

    // reply for the byte that is about to be shifted
    always_comb begin
        reply_next = '0;
        if (byte_idx == 4'd0) begin
            reply_next = `USER_IO_CORE_TYPE;
        end else begin
            case (cur_cmd)
                CMD_KBD_READ: begin
                    if (byte_idx == 4'd1) begin
                        reply_next = {`USER_IO_KBD_STATUS_TAG, 3'b000, kbd_avail};
                    end else begin
                        reply_next = kbd_out_data;
                    end
                end
                CMD_SD_STATUS: begin
                    if (byte_idx == 4'd1) begin
                        reply_next = {`USER_IO_SD_STATUS_TAG, sd_conf, sd_sdhc, sd_wr, sd_rd};
                    end
                end
                default: ;
            endcase
        end
    end

    // whole byte is frozen at its first bit so the fields cannot tear
    always_ff @(negedge SPI_CLK) begin
        if (bit_idx == 3'd0) begin
            tx_byte <= reply_next;
        end
    end

    always_ff @(negedge SPI_CLK or posedge SPI_SS_IO) begin
        if (SPI_SS_IO) begin
            miso_q <= 1'b0;
        end else if (bit_idx == 3'd0) begin
            miso_q <= reply_next[7];
        end else begin
            miso_q <= tx_byte[~bit_idx];
        end
    end

    assign miso = spi_sel & miso_q;

endmodule

`default_nettype wire

//--- src/user_io_top.sv
`default_nettype none

`include "user_io_params.svh"

module user_io_top (
    input  logic                   SPI_CLK,
    input  logic                   SPI_SS_IO,
    input  logic                   spi_sel,
    input  logic                   spi_mosi,
    output logic                   spi_miso,
    output logic [1:0]             buttons,
    output logic [1:0]             switches,
    output logic                   scandoubler_disable,
    output logic                   ypbpr,
    output logic [7:0]             joy0,
    output logic [7:0]             joy1,
    input  logic [7:0]             kbd_out_data,
    input  logic                   kbd_out_strobe,
    output logic                   kbd_in_valid,
    output user_io_pkg::kbd_code_t kbd_in_data,
    input  logic                   kbd_in_ready,
    output logic                   kbd_overflow,
    output logic                   sd_dout_valid,
    output user_io_pkg::sd_item_t  sd_dout,
    input  logic                   sd_dout_ready,
    output logic                   sd_overflow,
    input  logic                   sd_conf,
    input  logic                   sd_sdhc,
    input  logic                   sd_rd,
    input  logic                   sd_wr
);
    import user_io_pkg::*;

    logic       byte_strobe;
    spi_byte_t  rx_byte;
    byte_idx_t  byte_idx;
    logic [2:0] bit_idx;
    user_cmd_t  cur_cmd;
    logic       kbd_avail;
    logic       kbd_push;
    kbd_code_t  kbd_push_item;
    logic       sd_push;
    sd_item_t   sd_push_item;

    spi_byte_rx u_rx (
        .SPI_CLK     (SPI_CLK),
        .SPI_SS_IO   (SPI_SS_IO),
        .spi_sel     (spi_sel),
        .mosi        (spi_mosi),
        .byte_strobe (byte_strobe),
        .rx_byte     (rx_byte),
        .byte_idx    (byte_idx),
        .bit_idx     (bit_idx)
    );

    cmd_decoder u_dec (
        .SPI_CLK             (SPI_CLK),
        .SPI_SS_IO           (SPI_SS_IO),
        .byte_strobe         (byte_strobe),
        .rx_byte             (rx_byte),
        .byte_idx            (byte_idx),
        .cur_cmd             (cur_cmd),
        .buttons             (buttons),
        .switches            (switches),
        .scandoubler_disable (scandoubler_disable),
        .ypbpr               (ypbpr),
        .joy0                (joy0),
        .joy1                (joy1),
        .kbd_push            (kbd_push),
        .kbd_push_item       (kbd_push_item),
        .sd_push             (sd_push),
        .sd_push_item        (sd_push_item),
        .kbd_out_strobe      (kbd_out_strobe),
        .kbd_avail           (kbd_avail)
    );

    // keyboard codes for the core
    byte_fifo #(.item_t(kbd_code_t), .DEPTH(`USER_IO_KBD_DEPTH)) kbd_fifo (
        .SPI_CLK   (SPI_CLK),
        .SPI_SS_IO (SPI_SS_IO),
        .push      (kbd_push),
        .push_item (kbd_push_item),
        .valid     (kbd_in_valid),
        .item      (kbd_in_data),
        .ready     (kbd_in_ready),
        .overflow  (kbd_overflow)
    );

    // sector and config bytes for the sd emulation
    byte_fifo #(.item_t(sd_item_t), .DEPTH(`USER_IO_SD_DEPTH)) sd_fifo (
        .SPI_CLK   (SPI_CLK),
        .SPI_SS_IO (SPI_SS_IO),
        .push      (sd_push),
        .push_item (sd_push_item),
        .valid     (sd_dout_valid),
        .item      (sd_dout),
        .ready     (sd_dout_ready),
        .overflow  (sd_overflow)
    );

    spi_reply_tx u_tx (
        .SPI_CLK      (SPI_CLK),
        .SPI_SS_IO    (SPI_SS_IO),
        .spi_sel      (spi_sel),
        .byte_idx     (byte_idx),
        .bit_idx      (bit_idx),
        .cur_cmd      (cur_cmd),
        .kbd_avail    (kbd_avail),
        .kbd_out_data (kbd_out_data),
        .sd_conf      (sd_conf),
        .sd_sdhc      (sd_sdhc),
        .sd_rd        (sd_rd),
        .sd_wr        (sd_wr),
        .miso         (spi_miso)
    );

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
`default_nettype none

module tb_clock (
    output logic SPI_CLK,
    output logic SPI_SS_IO
);
    // free running, period of 40
    initial begin
        SPI_CLK = 1'b0;
        forever #20 SPI_CLK = ~SPI_CLK;
    end

    // reset held over the first 16 rising edges
    initial begin
        SPI_SS_IO = 1'b1;
        repeat (16) @(posedge SPI_CLK);
        SPI_SS_IO <= 1'b0;
    end

endmodule

`default_nettype wire

//--- testbench/tb_user_io.sv
`default_nettype none

`include "user_io_params.svh"

module tb_user_io;
    import user_io_pkg::*;

    localparam int FRAMES = 80;
    localparam int LIMIT  = 16 + FRAMES * 120;

    logic       SPI_CLK;
    logic       SPI_SS_IO;
    logic       spi_sel;
    logic       spi_mosi;
    logic       spi_miso;
    logic [1:0] buttons;
    logic [1:0] switches;
    logic       scandoubler_disable;
    logic       ypbpr;
    logic [7:0] joy0;
    logic [7:0] joy1;
    logic [7:0] kbd_out_data;
    logic       kbd_out_strobe;
    logic       kbd_in_valid;
    kbd_code_t  kbd_in_data;
    logic       kbd_in_ready;
    logic       kbd_overflow;
    logic       sd_dout_valid;
    sd_item_t   sd_dout;
    logic       sd_dout_ready;
    logic       sd_overflow;
    logic       sd_conf;
    logic       sd_sdhc;
    logic       sd_rd;
    logic       sd_wr;

    logic [31:0] lfsr;
    logic [1:0]  drain_mode;
    spi_byte_t   cmd_list [8];
    spi_byte_t   frame_bytes [16];
    spi_byte_t   reply_bytes [16];
    logic        kbd_flag;
    int          cycles = 0;

    // reference model of the link, stepped at each rising edge
    spi_byte_t   m_shift = '0;
    int          m_bits = 0;
    int          m_bytes = 0;
    logic        m_got = 1'b0;
    spi_byte_t   m_byte = '0;
    int          m_idx = 0;
    spi_byte_t   m_cmd = '0;
    logic        m_kbd_push = 1'b0;
    kbd_code_t   m_kbd_item = '0;
    logic        m_sd_push = 1'b0;
    sd_item_t    m_sd_item = '0;
    kbd_code_t   m_kbd_q [$];
    sd_item_t    m_sd_q [$];
    logic        m_kbd_ovf = 1'b0;
    logic        m_sd_ovf = 1'b0;
    spi_byte_t   m_settings = '0;
    spi_byte_t   m_joy0 = '0;
    spi_byte_t   m_joy1 = '0;

    tb_clock clk_gen (
        .SPI_CLK   (SPI_CLK),
        .SPI_SS_IO (SPI_SS_IO)
    );

    user_io_top DUT (.*);

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_byte(input spi_byte_t got, input spi_byte_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t %s: got %02h expected %02h", $time, what, got, exp));
        end
    endtask

    task automatic check_kbd(input kbd_code_t got, input kbd_code_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t %s: got %02h expected %02h", $time, what, got, exp));
        end
    endtask

    task automatic check_sd(input sd_item_t got, input sd_item_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t %s: got %02h conf %0b expected %02h conf %0b",
                                $time, what, got.data, got.conf, exp.data, exp.conf));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t %s: got %0b expected %0b", $time, what, got, exp));
        end
    endtask

    // one clock, new ready values for the core side
    task automatic tick();
        @(posedge SPI_CLK);
        kbd_out_strobe <= 1'b0;
        case (drain_mode)
            2'd0: begin
                kbd_in_ready  <= (rand_bits(1) != 0);
                sd_dout_ready <= (rand_bits(1) != 0);
            end
            2'd1: begin
                kbd_in_ready  <= (rand_bits(3) == 0);
                sd_dout_ready <= (rand_bits(3) == 0);
            end
            2'd2: begin
                kbd_in_ready  <= 1'b0;
                sd_dout_ready <= 1'b0;
            end
            default: begin
                kbd_in_ready  <= 1'b1;
                sd_dout_ready <= 1'b1;
            end
        endcase
    endtask

    // miso seen at an edge belongs to the bit driven on the edge before
    task automatic send_frame(input int nbytes);
        int n;
        for (n = 0; n < nbytes * 8; n++) begin
            tick();
            if (n > 0) begin
                reply_bytes[(n - 1) / 8][7 - ((n - 1) % 8)] = spi_miso;
            end
            spi_sel  <= 1'b1;
            spi_mosi <= frame_bytes[n / 8][7 - (n % 8)];
        end
        tick();
        reply_bytes[nbytes - 1][0] = spi_miso;
        spi_sel  <= 1'b0;
        spi_mosi <= 1'b0;
    endtask

    task automatic check_reply(input int nbytes);
        spi_byte_t exp;
        for (int k = 0; k < nbytes; k++) begin
            exp = 8'h00;
            if (k == 0) begin
                exp = `USER_IO_CORE_TYPE;
            end else if (frame_bytes[0] == CMD_KBD_READ) begin
                exp = (k == 1) ? {`USER_IO_KBD_STATUS_TAG, 3'b000, kbd_flag} : kbd_out_data;
            end else if (frame_bytes[0] == CMD_SD_STATUS && k == 1) begin
                exp = {`USER_IO_SD_STATUS_TAG, sd_conf, sd_sdhc, sd_wr, sd_rd};
            end
            check_byte(reply_bytes[k], exp,
                       $sformatf("miso byte %0d of command %02h", k, frame_bytes[0]));
        end
        // the read acknowledges the key once byte 1 is through
        if (frame_bytes[0] == CMD_KBD_READ && nbytes > 1) begin
            kbd_flag = 1'b0;
        end
    endtask

    task automatic compare_outputs();
        check_bit(kbd_in_valid, m_kbd_q.size() != 0, "kbd_in_valid");
        if (m_kbd_q.size() != 0) begin
            check_kbd(kbd_in_data, m_kbd_q[0], "kbd_in_data");
        end
        check_bit(sd_dout_valid, m_sd_q.size() != 0, "sd_dout_valid");
        if (m_sd_q.size() != 0) begin
            check_sd(sd_dout, m_sd_q[0], "sd_dout");
        end
        check_bit(kbd_overflow, m_kbd_ovf, "kbd_overflow");
        check_bit(sd_overflow, m_sd_ovf, "sd_overflow");
        if (!spi_sel) begin
            check_byte({2'b00, ypbpr, scandoubler_disable, switches, buttons}, m_settings,
                       "button and video bits");
            check_byte(joy0, m_joy0, "joy0");
            check_byte(joy1, m_joy1, "joy1");
        end
    endtask

    // pipeline runs back to front so each stage sees last edge's values
    task automatic step_model();
        if (m_kbd_q.size() != 0 && kbd_in_ready) begin
            void'(m_kbd_q.pop_front());
        end
        if (m_kbd_push) begin
            if (m_kbd_q.size() < `USER_IO_KBD_DEPTH) begin
                m_kbd_q.push_back(m_kbd_item);
            end else begin
                m_kbd_ovf = 1'b1;
            end
        end
        if (m_sd_q.size() != 0 && sd_dout_ready) begin
            void'(m_sd_q.pop_front());
        end
        if (m_sd_push) begin
            if (m_sd_q.size() < `USER_IO_SD_DEPTH) begin
                m_sd_q.push_back(m_sd_item);
            end else begin
                m_sd_ovf = 1'b1;
            end
        end

        // decoder stage
        m_kbd_push = 1'b0;
        m_sd_push  = 1'b0;
        if (m_got && m_idx == 0) begin
            m_cmd = m_byte;
        end else if (m_got) begin
            case (m_cmd)
                CMD_BUTTONS:   if (m_idx == 1) m_settings = {2'b00, m_byte[5:0]};
                CMD_JOY0:      if (m_idx == 1) m_joy0 = m_byte;
                CMD_JOY1:      if (m_idx == 1) m_joy1 = m_byte;
                CMD_KBD_WRITE: begin
                    m_kbd_push = (m_idx == 1);
                    m_kbd_item = m_byte;
                end
                CMD_SD_SECTOR, CMD_SD_CONF: begin
                    m_sd_push      = 1'b1;
                    m_sd_item.data = m_byte;
                    m_sd_item.conf = (m_cmd == CMD_SD_CONF);
                end
                default: ;
            endcase
        end

        // serial stage, msb first
        m_got = 1'b0;
        if (spi_sel) begin
            m_shift = {m_shift[6:0], spi_mosi};
            m_bits++;
            if (m_bits == 8) begin
                m_got  = 1'b1;
                m_byte = m_shift;
                m_idx  = m_bytes;
                m_bytes++;
                m_bits = 0;
            end
        end else begin
            m_bits  = 0;
            m_bytes = 0;
        end
    endtask

    always @(posedge SPI_CLK) begin
        if (!SPI_SS_IO) begin
            compare_outputs();
            step_model();
        end
    end

    always @(posedge SPI_CLK) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            abort_run($sformatf("timeout: test did not finish within %0d cycles", LIMIT));
        end
    end

    initial begin
        int        frame;
        int        nbytes;
        int        k;
        spi_byte_t cmd;
        lfsr           = 32'h1cb59176;
        drain_mode     = 2'd0;
        kbd_flag       = 1'b0;
        spi_sel        = 1'b0;
        spi_mosi       = 1'b0;
        kbd_out_data   = 8'h00;
        kbd_out_strobe = 1'b0;
        kbd_in_ready   = 1'b0;
        sd_dout_ready  = 1'b0;
        sd_conf        = 1'b0;
        sd_sdhc        = 1'b0;
        sd_rd          = 1'b0;
        sd_wr          = 1'b0;
        cmd_list = '{CMD_BUTTONS, CMD_KBD_READ, CMD_KBD_WRITE, CMD_SD_STATUS,
                     CMD_SD_SECTOR, CMD_SD_CONF, CMD_JOY0, CMD_JOY1};

        @(negedge SPI_SS_IO);
        tick();
        check_bit(spi_miso, 1'b0, "spi_miso after reset");
        check_bit(kbd_in_valid, 1'b0, "kbd_in_valid after reset");
        check_bit(sd_dout_valid, 1'b0, "sd_dout_valid after reset");
        check_bit(kbd_overflow, 1'b0, "kbd_overflow after reset");
        check_bit(sd_overflow, 1'b0, "sd_overflow after reset");
        check_byte({2'b00, ypbpr, scandoubler_disable, switches, buttons}, 8'h00,
                   "button and video bits after reset");
        check_byte(joy0, 8'h00, "joy0 after reset");
        check_byte(joy1, 8'h00, "joy1 after reset");

        for (frame = 0; frame < FRAMES; frame++) begin
            drain_mode = 2'(rand_bits(2));
            k = int'(rand_bits(4));
            // mostly known commands, now and then an arbitrary byte
            cmd = (k < 14) ? cmd_list[k % 8] : 8'(rand_bits(8));
            if (cmd == CMD_SD_SECTOR || cmd == CMD_SD_CONF) begin
                nbytes = 2 + int'(rand_bits(4) % 11);
            end else begin
                nbytes = 1 + int'(rand_bits(2));
            end
            frame_bytes[0] = cmd;
            for (k = 1; k < nbytes; k++) begin
                frame_bytes[k] = 8'(rand_bits(8));
            end
            send_frame(nbytes);
            check_reply(nbytes);

            // gap between frames, core side inputs may move here
            if (rand_bits(1) != 0) begin
                kbd_out_strobe <= 1'b1;
                kbd_out_data   <= 8'(rand_bits(8));
                kbd_flag = 1'b1;
            end
            {sd_conf, sd_sdhc, sd_rd, sd_wr} <= 4'(rand_bits(4));
            repeat (int'(rand_bits(2) % 3)) tick();
        end

        // let both queues run dry
        drain_mode = 2'd3;
        repeat (4) tick();
        while (m_kbd_q.size() != 0 || m_sd_q.size() != 0) begin
            tick();
        end
        repeat (2) tick();
        check_bit(kbd_in_valid, 1'b0, "kbd_in_valid after drain");
        check_bit(sd_dout_valid, 1'b0, "sd_dout_valid after drain");
        $display("%0d frames, kbd overflow %0b, sd overflow %0b",
                 FRAMES, m_kbd_ovf, m_sd_ovf);
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+src
src/user_io_pkg.sv
src/byte_fifo.sv
src/spi_byte_rx.sv
src/cmd_decoder.sv
src/spi_reply_tx.sv
src/user_io_top.sv
testbench/tb_clock.sv
testbench/tb_user_io.sv

//--- Makefile
TOP := tb_user_io

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -o sim_$(TOP)
	@out=$$(obj_dir/sim_$(TOP) 2>&1); echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir
